/* Makefile */
# Verilator flow for the out-of-order core testbench

VERILATOR ?= verilator
TOP       ?= tb_ooo_core
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* exec_units.sv */
//////////////////////////////
// adder with holding register, pipelined multiplier,
// cdb arbitration with the multiplier first
//////////////////////////////
`default_nettype none
`include "ooo_defs.svh"

module exec_units (
	input  logic clock,
	input  logic rst_n,
	output logic alu_busy,
	dispatch_if.exec disp,
	cdb_if.source cdb
);
	localparam int LAST = `MUL_STAGES - 1;

	logic alu_valid;                        // holding register occupied
	ooo_pkg::word_t alu_value;
	ooo_pkg::prn_t alu_tag;
	ooo_pkg::rob_idx_t alu_rob;
	logic [`MUL_STAGES-1:0] mul_valid;      // one bit per stage
	ooo_pkg::word_t mul_value [`MUL_STAGES];
	ooo_pkg::prn_t mul_tag [`MUL_STAGES];
	ooo_pkg::rob_idx_t mul_rob [`MUL_STAGES];
	logic issue_add, issue_mul, alu_grant;

	assign issue_add = disp.fire && !disp.done_now && (disp.fu_sel == ooo_pkg::FU_ADD);
	assign issue_mul = disp.fire && !disp.done_now && (disp.fu_sel == ooo_pkg::FU_MUL);
	assign alu_grant = alu_valid && !mul_valid[LAST];      // bus free of products
	assign alu_busy = alu_valid && mul_valid[LAST];        // cannot drain this cycle

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			alu_valid <= 1'b0;
			mul_valid <= '0;
		end else begin
			mul_valid <= {mul_valid[`MUL_STAGES-2:0], issue_mul};
			if (issue_add) begin
				alu_valid <= 1'b1;                       // refill as the old one leaves
			end else if (alu_grant) begin
				alu_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (issue_add) begin
			alu_value <= disp.opa_value + disp.opb_value;
			alu_tag <= disp.prn_dest;
			alu_rob <= disp.rob_idx;
		end
		mul_value[0] <= disp.opa_value * disp.opb_value;  // low product bits
		mul_tag[0] <= disp.prn_dest;
		mul_rob[0] <= disp.rob_idx;
		for (int s = 1; s < `MUL_STAGES; s++) begin
			mul_value[s] <= mul_value[s-1];
			mul_tag[s] <= mul_tag[s-1];
			mul_rob[s] <= mul_rob[s-1];
		end
	end

	// multiplier owns the bus whenever its last stage is valid
	assign cdb.valid = mul_valid[LAST] || alu_valid;
	assign cdb.tag = mul_valid[LAST] ? mul_tag[LAST] : alu_tag;
	assign cdb.value = mul_valid[LAST] ? mul_value[LAST] : alu_value;
	assign cdb.rob_idx = mul_valid[LAST] ? mul_rob[LAST] : alu_rob;

endmodule

`default_nettype wire

/* ooo_core.sv */
//////////////////////////////
// out-of-order core top: control, rename,
// register file, reorder buffer, execution
//////////////////////////////
`default_nettype none

module ooo_core (
	input  logic clock,
	input  logic rst_n,
	input  logic dispatch_valid,
	input  logic [31:0] dispatch_inst,
	output logic dispatch_stall,
	output logic commit_valid,
	output logic commit_wr_en,
	output ooo_pkg::arn_t commit_arn_dest,
	output ooo_pkg::word_t commit_value,
	output ooo_pkg::error_code_t error_status
);
	cdb_if cdb_bus();
	dispatch_if disp_bus();
	retire_if ret_bus();

	ooo_pkg::arn_t src_arn_a, src_arn_b;
	ooo_pkg::prn_t src_prn_a, src_prn_b;
	ooo_pkg::word_t src_value_a, src_value_b;
	logic src_ready_a, src_ready_b;
	logic rob_full, free_empty, alu_busy;  // structural stall sources

	ooo_ctrl ctrl_i (.clock, .rst_n, .dispatch_valid,
		.dispatch_inst(ooo_pkg::inst_u'(dispatch_inst)),
		.src_value_a, .src_value_b, .src_ready_a, .src_ready_b,
		.rob_full, .free_empty, .alu_busy, .src_arn_a, .src_arn_b,
		.dispatch_stall, .error_status, .disp(disp_bus), .ret(ret_bus));
	rename_table rename_i (.clock, .rst_n, .src_arn_a, .src_arn_b, .src_prn_a, .src_prn_b,
		.free_empty, .disp(disp_bus), .ret(ret_bus));
	prf prf_i (.clock, .rst_n, .src_prn_a, .src_prn_b, .src_value_a, .src_value_b,
		.src_ready_a, .src_ready_b, .commit_value, .cdb(cdb_bus), .disp(disp_bus),
		.ret(ret_bus));
	rob rob_i (.clock, .rst_n, .rob_full, .disp(disp_bus), .cdb(cdb_bus), .ret(ret_bus));
	exec_units exec_i (.clock, .rst_n, .alu_busy, .disp(disp_bus), .cdb(cdb_bus));

	assign commit_valid = ret_bus.valid;
	assign commit_wr_en = ret_bus.has_dest;                // zero dest never writes
	assign commit_arn_dest = ret_bus.arn_dest;

endmodule

`default_nettype wire

/* ooo_core_asserts.sv */
//////////////////////////////
// concurrent checks on the core top ports,
// bound into ooo_core
//////////////////////////////
`default_nettype none

module ooo_core_asserts (
	input logic clock,
	input logic rst_n,
	input logic dispatch_stall,
	input logic commit_valid,
	input logic commit_wr_en,
	input ooo_pkg::arn_t commit_arn_dest,
	input ooo_pkg::error_code_t error_status
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;                        // read by the testbench at the end

	// a halted core refuses every dispatch and keeps its error code until reset
	stall_when_halted: assert property (@(posedge clock) disable iff (!rst_n)
		error_status != ooo_pkg::NO_ERROR |->
			dispatch_stall ##1 (dispatch_stall && $stable(error_status)))
		else begin
			$error("dispatch_stall low or error_status changed while halted");
			fail_count++;
		end

	no_zero_write: assert property (@(posedge clock) disable iff (!rst_n)
		commit_wr_en |-> commit_arn_dest != '0)
		else begin
			$error("commit_wr_en high for architectural register 0");
			fail_count++;
		end

	commit_known: assert property (@(posedge clock) disable iff (!rst_n)
		!$isunknown(commit_valid))
		else begin
			$error("commit_valid is unknown");
			fail_count++;
		end

endmodule

bind ooo_core ooo_core_asserts asserts_i (.*);

`default_nettype wire

/* ooo_ctrl.sv */
//////////////////////////////
// control: instruction decode, stall level,
// sticky error status
//////////////////////////////
`default_nettype none
`include "ooo_defs.svh"

module ooo_ctrl (
	input  logic clock,
	input  logic rst_n,
	input  logic dispatch_valid,
	input  ooo_pkg::inst_u dispatch_inst,
	input  ooo_pkg::word_t src_value_a,
	input  ooo_pkg::word_t src_value_b,
	input  logic src_ready_a,
	input  logic src_ready_b,
	input  logic rob_full,
	input  logic free_empty,
	input  logic alu_busy,
	output ooo_pkg::arn_t src_arn_a,
	output ooo_pkg::arn_t src_arn_b,
	output logic dispatch_stall,
	output ooo_pkg::error_code_t error_status,
	dispatch_if.ctrl disp,
	retire_if.sink ret
);
	ooo_pkg::opcode_t op;
	logic is_imm, is_mul, is_halt, is_illegal;
	logic operand_wait;
	ooo_pkg::word_t imm_ext;

	assign op = dispatch_inst.r.opcode;                     // same field in both views
	assign is_imm = (op == ooo_pkg::OP_ADDI) || (op == ooo_pkg::OP_MULI);
	assign is_mul = (op == ooo_pkg::OP_MUL) || (op == ooo_pkg::OP_MULI);
	assign is_halt = op == ooo_pkg::OP_HALT;
	assign is_illegal = !(is_imm || is_mul || is_halt || op == ooo_pkg::OP_ADD);
	assign imm_ext = {{(`DATA_W-16){dispatch_inst.i.imm[15]}}, dispatch_inst.i.imm};

	assign src_arn_a = dispatch_inst.r.opa;
	assign src_arn_b = dispatch_inst.r.opb;                 // ignored for imm forms

	// a waits for ra unless it needs no execution, b only in register form
	assign operand_wait = !disp.done_now && (!src_ready_a || (!is_imm && !src_ready_b));
	assign dispatch_stall = (dispatch_valid && operand_wait) || rob_full || free_empty ||
		alu_busy || (error_status != ooo_pkg::NO_ERROR);

	assign disp.fire = dispatch_valid && !dispatch_stall;
	assign disp.arn_dest = dispatch_inst.r.dest;
	assign disp.done_now = is_halt || is_illegal;
	assign disp.rename_en = !disp.done_now && (dispatch_inst.r.dest != `ZERO_REG);
	assign disp.fu_sel = is_mul ? ooo_pkg::FU_MUL : ooo_pkg::FU_ADD;
	assign disp.opa_value = src_value_a;
	assign disp.opb_value = is_imm ? imm_ext : src_value_b;
	assign disp.err_code = is_illegal ? ooo_pkg::HALTED_ON_ILLEGAL :
		is_halt ? ooo_pkg::HALTED_ON_HALT : ooo_pkg::NO_ERROR;

	// first error to retire sticks until reset
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			error_status <= ooo_pkg::NO_ERROR;
		end else if (ret.valid && ret.err_code != ooo_pkg::NO_ERROR &&
				error_status == ooo_pkg::NO_ERROR) begin
			error_status <= ret.err_code;
		end
	end

endmodule

`default_nettype wire

/* ooo_defs.svh */
//////////////////////////////
// core sizing macros: data width, register file and
// reorder buffer depths, multiplier latency
//////////////////////////////
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

`define DATA_W      64  // operand and result width
`define ARF_SIZE    32  // architectural registers
`define PRF_SIZE    64  // physical registers
`define ROB_SIZE    16  // reorder buffer slots
`define MUL_STAGES  3   // multiply latency in cycles

// always reads zero, never renamed
`define ZERO_REG    0

`endif

/* ooo_if.sv */
//////////////////////////////
// cdb_if: single result bus
// dispatch_if: accepted op with rename and slot info
// retire_if: head of the reorder buffer
//////////////////////////////
`default_nettype none

interface cdb_if;
	logic valid;                    // one pulse per result
	ooo_pkg::prn_t tag;             // physical dest to write
	ooo_pkg::word_t value;
	ooo_pkg::rob_idx_t rob_idx;     // slot to mark done
	modport source (output valid, tag, value, rob_idx);
	modport sink (input valid, tag, value, rob_idx);
endinterface

interface dispatch_if;
	logic fire;                     // instruction accepted this cycle
	ooo_pkg::arn_t arn_dest;
	logic rename_en;                // dest is not the zero reg
	ooo_pkg::fu_sel_t fu_sel;
	ooo_pkg::word_t opa_value;
	ooo_pkg::word_t opb_value;      // reg value or extended imm
	logic done_now;                 // halt or illegal, no execution
	ooo_pkg::error_code_t err_code;
	ooo_pkg::rob_idx_t rob_idx;     // tail slot from rob
	ooo_pkg::prn_t prn_dest;        // new mapping from rename
	ooo_pkg::prn_t old_prn;         // mapping being replaced
	modport ctrl (output fire, arn_dest, rename_en, fu_sel, opa_value, opb_value,
		done_now, err_code);
	modport rename (input fire, arn_dest, rename_en, output prn_dest, old_prn);
	modport rob (input fire, arn_dest, rename_en, done_now, err_code, prn_dest, old_prn,
		output rob_idx);
	modport exec (input fire, fu_sel, opa_value, opb_value, done_now, prn_dest, rob_idx);
endinterface

interface retire_if;
	logic valid;                    // head retires this cycle
	ooo_pkg::arn_t arn_dest;
	ooo_pkg::prn_t prn_dest;        // holds the committed value
	ooo_pkg::prn_t old_prn;         // goes back to the free list
	logic has_dest;
	ooo_pkg::error_code_t err_code;
	modport source (output valid, arn_dest, prn_dest, old_prn, has_dest, err_code);
	modport sink (input valid, arn_dest, prn_dest, old_prn, has_dest, err_code);
endinterface

`default_nettype wire

/* ooo_pkg.sv */
//////////////////////////////
// shared types: register and slot indices, opcodes,
// unit select, error codes, instruction word views
//////////////////////////////
`default_nettype none
`include "ooo_defs.svh"

package ooo_pkg;

	typedef logic [$clog2(`ARF_SIZE)-1:0] arn_t;    // architectural index
	typedef logic [$clog2(`PRF_SIZE)-1:0] prn_t;    // physical index
	typedef logic [$clog2(`ROB_SIZE)-1:0] rob_idx_t;
	typedef logic [`DATA_W-1:0] word_t;

	typedef enum logic [5:0] {
		OP_HALT = 6'h00,
		OP_ADD  = 6'h10,    // rd = ra + rb
		OP_ADDI = 6'h11,    // rd = ra + sext(imm)
		OP_MUL  = 6'h12,
		OP_MULI = 6'h13
	} opcode_t;

	typedef enum logic {FU_ADD, FU_MUL} fu_sel_t;

	typedef enum logic [1:0] {NO_ERROR, HALTED_ON_HALT, HALTED_ON_ILLEGAL} error_code_t;

	typedef struct packed {
		opcode_t opcode;
		arn_t dest;
		arn_t opa;
		arn_t opb;
		logic [10:0] pad;   // unused in register form
	} inst_reg_t;

	typedef struct packed {
		opcode_t opcode;
		arn_t dest;
		arn_t opa;
		logic signed [15:0] imm;
	} inst_imm_t;

	// same 32-bit word, register or immediate form
	typedef union packed {
		inst_reg_t r;
		inst_imm_t i;
	} inst_u;

endpackage

`default_nettype wire

/* prf.sv */
//////////////////////////////
// physical register values and ready bits
// cdb write, two source reads, commit read
//////////////////////////////
`default_nettype none
`include "ooo_defs.svh"

module prf (
	input  logic clock,
	input  logic rst_n,
	input  ooo_pkg::prn_t src_prn_a,
	input  ooo_pkg::prn_t src_prn_b,
	output ooo_pkg::word_t src_value_a,
	output ooo_pkg::word_t src_value_b,
	output logic src_ready_a,
	output logic src_ready_b,
	output ooo_pkg::word_t commit_value,
	cdb_if.sink cdb,
	dispatch_if.rename disp,
	retire_if.sink ret
);
	// arch zero maps here forever
	localparam ooo_pkg::prn_t ZERO_PRN = ooo_pkg::prn_t'(`ZERO_REG);

	ooo_pkg::word_t value [`PRF_SIZE];
	logic [`PRF_SIZE-1:0] ready;

	assign src_value_a = (src_prn_a == ZERO_PRN) ? '0 : value[src_prn_a];
	assign src_value_b = (src_prn_b == ZERO_PRN) ? '0 : value[src_prn_b];
	assign src_ready_a = (src_prn_a == ZERO_PRN) || ready[src_prn_a];
	assign src_ready_b = (src_prn_b == ZERO_PRN) || ready[src_prn_b];
	assign commit_value = value[ret.prn_dest];             // written a cycle before retire

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `PRF_SIZE; i++) begin
				value[i] <= '0;                          // arch regs start at zero
			end
			ready <= '1;
		end else begin
			if (disp.fire && disp.rename_en) begin
				ready[disp.prn_dest] <= 1'b0;            // busy until its result shows
			end
			if (cdb.valid && cdb.tag != ZERO_PRN) begin
				value[cdb.tag] <= cdb.value;
				ready[cdb.tag] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* rename_table.sv */
//////////////////////////////
// map table arch -> phys
// free list as a bit vector, lowest index first
//////////////////////////////
`default_nettype none
`include "ooo_defs.svh"

module rename_table (
	input  logic clock,
	input  logic rst_n,
	input  ooo_pkg::arn_t src_arn_a,
	input  ooo_pkg::arn_t src_arn_b,
	output ooo_pkg::prn_t src_prn_a,
	output ooo_pkg::prn_t src_prn_b,
	output logic free_empty,
	dispatch_if.rename disp,
	retire_if.sink ret
);
	ooo_pkg::prn_t map [`ARF_SIZE];         // current speculative mapping
	logic [`PRF_SIZE-1:0] free;             // 1 = available
	ooo_pkg::prn_t alloc;                   // lowest free entry

	//////////////////////////////
	// allocation
	//////////////////////////////
	always_comb begin
		alloc = '0;
		for (int i = `PRF_SIZE-1; i >= 0; i--) begin   // descending so lowest wins
			if (free[i]) begin
				alloc = ooo_pkg::prn_t'(i);
			end
		end
	end

	assign free_empty = ~|free;
	assign src_prn_a = map[src_arn_a];
	assign src_prn_b = map[src_arn_b];
	assign disp.old_prn = map[disp.arn_dest];
	// zero dest keeps its fixed mapping, its result is dropped by the prf
	assign disp.prn_dest = disp.rename_en ? alloc : map[disp.arn_dest];

	//////////////////////////////
	// update
	//////////////////////////////
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `ARF_SIZE; i++) begin
				map[i] <= ooo_pkg::prn_t'(i);            // identity after reset
			end
			free <= {{(`PRF_SIZE-`ARF_SIZE){1'b1}}, {`ARF_SIZE{1'b0}}};
		end else begin
			if (ret.valid && ret.has_dest) begin
				free[ret.old_prn] <= 1'b1;               // previous mapping is dead now
			end
			if (disp.fire && disp.rename_en) begin
				map[disp.arn_dest] <= alloc;
				free[alloc] <= 1'b0;                     // never equal to old_prn
			end
		end
	end

endmodule

`default_nettype wire

/* rob.sv */
//////////////////////////////
// reorder buffer: circular, head/tail/count
// done marking from cdb, in-order retire
//////////////////////////////
`default_nettype none
`include "ooo_defs.svh"

module rob (
	input  logic clock,
	input  logic rst_n,
	output logic rob_full,
	dispatch_if.rob disp,
	cdb_if.sink cdb,
	retire_if.source ret
);
	localparam int CNT_W = $clog2(`ROB_SIZE) + 1;

	ooo_pkg::arn_t arn_q [`ROB_SIZE];
	ooo_pkg::prn_t prn_q [`ROB_SIZE];
	ooo_pkg::prn_t old_q [`ROB_SIZE];
	ooo_pkg::error_code_t err_q [`ROB_SIZE];
	logic [`ROB_SIZE-1:0] has_dest_q;
	logic [`ROB_SIZE-1:0] done_q;          // result on cdb or needs none
	ooo_pkg::rob_idx_t head, tail;
	logic [CNT_W-1:0] count;               // occupied slots

	assign rob_full = count == CNT_W'(`ROB_SIZE);
	assign disp.rob_idx = tail;

	//////////////////////////////
	// retire port
	//////////////////////////////
	assign ret.valid = (count != '0) && done_q[head];
	assign ret.arn_dest = arn_q[head];
	assign ret.prn_dest = prn_q[head];
	assign ret.old_prn = old_q[head];
	assign ret.has_dest = ret.valid && has_dest_q[head];   // low between retires
	assign ret.err_code = ret.valid ? err_q[head] : ooo_pkg::NO_ERROR;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			done_q <= '0;
		end else begin
			if (disp.fire) begin
				tail <= tail + 1'b1;                     // wraps with the slot count
				done_q[tail] <= disp.done_now;          // halt/illegal retire next cycle
			end
			if (cdb.valid) begin
				done_q[cdb.rob_idx] <= 1'b1;
			end
			if (ret.valid) begin
				head <= head + 1'b1;
			end
			count <= count + CNT_W'(disp.fire) - CNT_W'(ret.valid);
		end
	end

	// entry payload
	always_ff @(posedge clock) begin
		if (disp.fire) begin
			arn_q[tail] <= disp.arn_dest;
			prn_q[tail] <= disp.prn_dest;
			old_q[tail] <= disp.old_prn;
			err_q[tail] <= disp.err_code;
			has_dest_q[tail] <= disp.rename_en;
		end
	end

endmodule

`default_nettype wire

/* tb_ooo_core.sv */
//////////////////////////////
// testbench for the out-of-order core: directed tests,
// lcg instruction stream, architectural reference model,
// commit monitor, clock and reset
//////////////////////////////
`default_nettype none

module tb_ooo_core;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT = 400;           // cycles allowed per wait

	logic clock;
	logic rst_n;
	logic dispatch_valid;
	logic [31:0] dispatch_inst;
	logic dispatch_stall, commit_valid, commit_wr_en;
	ooo_pkg::arn_t commit_arn_dest;
	ooo_pkg::word_t commit_value;
	ooo_pkg::error_code_t error_status;

	logic [63:0] arf [32];                     // reference register values
	logic [69:0] exp_q [$];                    // {wr_en, arn, value} in program order
	logic [69:0] head_exp;
	logic [31:0] rng;
	int err_count, check_count;
	bit aborted;                               // a wait ran out, skip the rest

	ooo_core ooo_core_i (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;              // 8 ns period
	end

	task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERROR %0t ns %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(input string why);
		err_count++;
		$display("%0t ns: %s", $time, why);
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] reg_word(input logic [5:0] op, input logic [4:0] d,
			input logic [4:0] a, input logic [4:0] b);
		return {op, d, a, b, 11'd0};
	endfunction

	function automatic logic [31:0] imm_word(input logic [5:0] op, input logic [4:0] d,
			input logic [4:0] a, input logic [15:0] imm);
		return {op, d, a, imm};
	endfunction

	//////////////////////////////
	// reference model, program order
	//////////////////////////////
	task automatic model_step(input logic [31:0] w);
		logic [5:0] op;
		logic [4:0] d, a, b;
		logic [63:0] imm, res;
		logic wr;
		op = w[31:26];
		d = w[25:21];
		a = w[20:16];
		b = w[15:11];
		imm = {{48{w[15]}}, w[15:0]};             // sign extended immediate
		res = '0;
		wr = 1'b1;
		case (op)
			ooo_pkg::OP_ADD:  res = arf[a] + arf[b];
			ooo_pkg::OP_ADDI: res = arf[a] + imm;
			ooo_pkg::OP_MUL:  res = arf[a] * arf[b];  // low 64 bits
			ooo_pkg::OP_MULI: res = arf[a] * imm;
			default: wr = 1'b0;                   // halt and illegal write nothing
		endcase
		if (d == 5'd0) begin
			wr = 1'b0;
		end
		if (wr) begin
			arf[d] = res;
		end
		exp_q.push_back({wr, d, res});
	endtask

	// commits are checked against the model as they come out
	always @(negedge clock) begin
		if (rst_n && commit_valid) begin
			if (exp_q.size() == 0) begin
				report_failure("commit seen with no instruction outstanding");
			end else begin
				head_exp = exp_q.pop_front();
				check_eq("commit_wr_en", 64'(commit_wr_en), 64'(head_exp[69]));
				check_eq("commit_arn_dest", 64'(commit_arn_dest), 64'(head_exp[68:64]));
				if (head_exp[69]) begin
					check_eq("commit_value", commit_value, head_exp[63:0]);
				end
			end
		end
	end

	//////////////////////////////
	// drive helpers
	//////////////////////////////
	task automatic apply_reset();
		@(negedge clock);
		rst_n = 1'b0;
		dispatch_valid = 1'b0;
		exp_q.delete();
		for (int i = 0; i < 32; i++) begin
			arf[i] = '0;
		end
		repeat (2) @(negedge clock);
		rst_n = 1'b1;
	endtask

	// called at a falling edge, returns at the one after acceptance
	task automatic issue(input logic [31:0] w);
		int waited;
		waited = 0;
		if (aborted) begin
			return;
		end
		dispatch_valid = 1'b1;
		dispatch_inst = w;
		#1;
		while (dispatch_stall) begin
			if (waited == WAIT_LIMIT) begin
				report_failure("dispatch stayed stalled past the wait limit");
				aborted = 1'b1;
				return;
			end
			@(negedge clock);
			#1;
			waited++;
		end
		model_step(w);
		@(negedge clock);
		dispatch_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && !aborted) begin
			if (waited == WAIT_LIMIT) begin
				report_failure("expected commits did not arrive within the wait limit");
				aborted = 1'b1;
			end else begin
				@(posedge clock);                 // monitor pops on the falling edge
				waited++;
			end
		end
		@(negedge clock);
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////
	task automatic test_reset_state();
		apply_reset();
		#1;
		check_eq("dispatch_stall", 64'(dispatch_stall), 64'd0);
		check_eq("commit_valid", 64'(commit_valid), 64'd0);
		check_eq("error_status", 64'(error_status), 64'(ooo_pkg::NO_ERROR));
		@(negedge clock);
	endtask

	task automatic test_single_adds();
		issue(imm_word(ooo_pkg::OP_ADDI, 5'd1, 5'd0, 16'h0123));
		issue(imm_word(ooo_pkg::OP_ADDI, 5'd2, 5'd0, 16'hfff0));   // negative immediate
		issue(reg_word(ooo_pkg::OP_ADD, 5'd3, 5'd1, 5'd2));
		wait_drain();
	endtask

	task automatic test_in_order();
		issue(imm_word(ooo_pkg::OP_ADDI, 5'd5, 5'd0, 16'd7));
		issue(imm_word(ooo_pkg::OP_ADDI, 5'd6, 5'd0, 16'hfffd));
		issue(reg_word(ooo_pkg::OP_MUL, 5'd10, 5'd1, 5'd2));       // slow
		issue(reg_word(ooo_pkg::OP_ADD, 5'd11, 5'd5, 5'd6));       // independent, fast
		issue(reg_word(ooo_pkg::OP_ADD, 5'd12, 5'd10, 5'd1));      // waits on the product
		issue(imm_word(ooo_pkg::OP_MULI, 5'd13, 5'd12, 16'd9));
		wait_drain();
	endtask

	task automatic test_zero_reg();
		issue(imm_word(ooo_pkg::OP_ADDI, 5'd0, 5'd0, 16'd5));      // result dropped
		issue(reg_word(ooo_pkg::OP_ADD, 5'd14, 5'd0, 5'd0));
		issue(imm_word(ooo_pkg::OP_ADDI, 5'd15, 5'd0, 16'h0055));
		wait_drain();
	endtask

	task automatic test_random_stream();
		logic [5:0] op;
		for (int n = 0; n < 200; n++) begin
			rng = lcg_next(rng);
			case (rng[31:30])
				2'd0: op = ooo_pkg::OP_ADD;
				2'd1: op = ooo_pkg::OP_ADDI;
				2'd2: op = ooo_pkg::OP_MUL;
				default: op = ooo_pkg::OP_MULI;
			endcase
			issue({op, rng[27:23], rng[22:18], rng[17:2]});
		end
		wait_drain();
	endtask

	task automatic test_halt_illegal();
		issue(reg_word(ooo_pkg::OP_HALT, 5'd0, 5'd0, 5'd0));
		wait_drain();
		check_eq("error_status", 64'(error_status), 64'(ooo_pkg::HALTED_ON_HALT));
		dispatch_valid = 1'b1;
		dispatch_inst = imm_word(ooo_pkg::OP_ADDI, 5'd1, 5'd0, 16'd1);
		repeat (4) begin
			#1;
			check_eq("dispatch_stall", 64'(dispatch_stall), 64'd1);
			@(negedge clock);
		end
		dispatch_valid = 1'b0;
		apply_reset();
		issue(32'hfc00_0000);                   // opcode 6'h3f is undefined
		wait_drain();
		check_eq("error_status", 64'(error_status), 64'(ooo_pkg::HALTED_ON_ILLEGAL));
	endtask

	initial begin
		rst_n = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_inst = '0;
		rng = 32'd67302;
		err_count = 0;
		check_count = 0;
		aborted = 1'b0;
		test_reset_state();
		test_single_adds();
		test_in_order();
		test_zero_reg();
		test_random_stream();
		test_halt_illegal();
		err_count += ooo_core_i.asserts_i.fail_count;
		$display("checks: %0d  errors: %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
ooo_pkg.sv
ooo_if.sv
ooo_ctrl.sv
rename_table.sv
prf.sv
rob.sv
exec_units.sv
ooo_core.sv
ooo_core_asserts.sv
tb_ooo_core.sv
